//--- hdl/periph_bridge_defines.svh
// ----------------------------------------------------------
// Peripheral bridge defines
// Slot count, accelerator address map and bus widths
// ----------------------------------------------------------

`ifndef PERIPH_BRIDGE_DEFINES_SVH
`define PERIPH_BRIDGE_DEFINES_SVH

// ----------------------------------------------------------
// Slot layout
// ----------------------------------------------------------

// Accelerator slots behind the bridge
`define PB_NUM_SLOTS 3

// Slot 0 window base, later slots follow back to back
`define PB_BASE_ADDR 32'h8004_0000

// Each window is 64 KiB
`define PB_SLOT_SPAN_BITS 16

// ----------------------------------------------------------
// Bus widths
// ----------------------------------------------------------

`define PB_DATA_W 32

// Register offset seen by the APB peripheral
`define PB_APB_ADDR_W 12

`endif

//--- hdl/bus_pkg.sv
// ----------------------------------------------------------
// Manager bus types
// Request and response bundles of the system bus manager port
// ----------------------------------------------------------

`include "periph_bridge_defines.svh"

package bus_pkg;

  // ----------------------------------------------------------
  // Request from the manager
  // ----------------------------------------------------------

  // Strobes are single-cycle pulses
  // Address and write data hold until the response
  typedef struct packed {
    logic [31:0]            addr;
    logic [`PB_DATA_W-1:0]  wdata;
    logic                   rd_req;
    logic                   wr_req;
  } mgr_req_t;

  // ----------------------------------------------------------
  // Response to the manager
  // ----------------------------------------------------------

  // One response pulse per request, for reads and writes alike
  // Read data is only meaningful in the pulse cycle
  typedef struct packed {
    logic [`PB_DATA_W-1:0]  rdata;
    logic                   rsp;
  } mgr_rsp_t;

endpackage

//--- hdl/apb_pkg.sv
// ----------------------------------------------------------
// APB types
// Peripheral-side request, response and bridge state encoding
// ----------------------------------------------------------

`include "periph_bridge_defines.svh"

package apb_pkg;

  // Signals driven by the bridge toward the peripheral
  typedef struct packed {
    logic [`PB_APB_ADDR_W-1:0]  paddr;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [`PB_DATA_W-1:0]      pwdata;
  } apb_req_t;

  // Signals returned by the peripheral
  typedef struct packed {
    logic [`PB_DATA_W-1:0]  prdata;
    logic                   pready;
  } apb_rsp_t;

  // Bridge sequencer states
  typedef enum logic [1:0] {
    APB_IDLE,
    APB_SETUP,
    APB_ACCESS
  } apb_state_e;

endpackage

//--- hdl/region_decoder.sv
// ----------------------------------------------------------
// Region decoder
// Steers manager strobes to the slot owning the address
// ----------------------------------------------------------

`timescale 1ns/1ps

`include "periph_bridge_defines.svh"

module region_decoder
  import bus_pkg::*;
(
  input  logic                          clock_i,
  input  logic                          reset_i,
  input  mgr_req_t                      mgr_req_i,
  output mgr_req_t [`PB_NUM_SLOTS-1:0]  slot_req_o,
  output logic                          unmapped_o
);

  localparam int unsigned win_w = 32 - `PB_SLOT_SPAN_BITS;
  localparam logic [31:0] base_addr = `PB_BASE_ADDR;

  logic [`PB_NUM_SLOTS-1:0] hit;
  logic                     strobe;
  logic                     unmapped_q;

  assign strobe = mgr_req_i.rd_req | mgr_req_i.wr_req;

  // ----------------------------------------------------------
  // Window match and strobe steering
  // ----------------------------------------------------------

  always_comb begin
    logic [win_w-1:0] slot_base;
    for (int n = 0; n < `PB_NUM_SLOTS; n++) begin
      slot_base = base_addr[31:`PB_SLOT_SPAN_BITS] + win_w'(n);
      hit[n] = (mgr_req_i.addr[31:`PB_SLOT_SPAN_BITS] == slot_base);
      // Address and data fan out, strobes only to the owner
      slot_req_o[n]        = mgr_req_i;
      slot_req_o[n].rd_req = mgr_req_i.rd_req & hit[n];
      slot_req_o[n].wr_req = mgr_req_i.wr_req & hit[n];
    end
  end

  // ----------------------------------------------------------
  // Unmapped access
  // ----------------------------------------------------------

  // Answered one cycle after the strobe
  always_ff @(posedge clock_i or posedge reset_i) begin
    if (reset_i) begin
      unmapped_q <= 1'b0;
    end else begin
      unmapped_q <= strobe & ~(|hit);
    end
  end

  assign unmapped_o = unmapped_q;

endmodule

//--- hdl/apb_slot_bridge.sv
// ----------------------------------------------------------
// APB slot bridge
// Converts one manager request into an APB setup/access
// transfer and latches the peripheral interrupt edge
// ----------------------------------------------------------

`timescale 1ns/1ps

`include "periph_bridge_defines.svh"

module apb_slot_bridge
  import bus_pkg::*, apb_pkg::*;
(
  input  logic      clock_i,
  input  logic      reset_i,
  input  mgr_req_t  slot_req_i,
  output mgr_rsp_t  slot_rsp_o,
  output apb_req_t  apb_req_o,
  input  apb_rsp_t  apb_rsp_i,
  input  logic      periph_irq_i,
  input  logic      irq_ack_i,
  output logic      irq_pending_o
);

  apb_state_e                 state_q;
  apb_state_e                 state_d;
  logic [`PB_APB_ADDR_W-1:0]  paddr_q;
  logic [`PB_DATA_W-1:0]      pwdata_q;
  logic                       pwrite_q;
  logic                       strobe;
  logic                       done;
  logic                       irq_q;
  logic                       pending_q;

  assign strobe = slot_req_i.rd_req | slot_req_i.wr_req;
  assign done   = (state_q == APB_ACCESS) & apb_rsp_i.pready;

  // ----------------------------------------------------------
  // Transfer sequencer
  // ----------------------------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      APB_IDLE:   if (strobe) state_d = APB_SETUP;
      APB_SETUP:  state_d = APB_ACCESS;
      // Wait states while pready is low
      APB_ACCESS: if (apb_rsp_i.pready) state_d = APB_IDLE;
      default:    state_d = APB_IDLE;
    endcase
  end

  always_ff @(posedge clock_i or posedge reset_i) begin
    if (reset_i) begin
      state_q <= APB_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture the request, held stable for the whole transfer
  always_ff @(posedge clock_i) begin
    if (state_q == APB_IDLE && strobe) begin
      paddr_q  <= slot_req_i.addr[`PB_APB_ADDR_W-1:0];
      pwdata_q <= slot_req_i.wdata;
      pwrite_q <= slot_req_i.wr_req;
    end
  end

  assign apb_req_o.paddr   = paddr_q;
  assign apb_req_o.psel    = (state_q != APB_IDLE);
  assign apb_req_o.penable = (state_q == APB_ACCESS);
  assign apb_req_o.pwrite  = pwrite_q;
  assign apb_req_o.pwdata  = pwdata_q;

  // Response in the completing access cycle
  assign slot_rsp_o.rsp   = done;
  assign slot_rsp_o.rdata = apb_rsp_i.prdata;

  // ----------------------------------------------------------
  // Interrupt pending latch
  // ----------------------------------------------------------

  // New edge takes priority over a same-cycle acknowledge
  always_ff @(posedge clock_i or posedge reset_i) begin
    if (reset_i) begin
      irq_q     <= 1'b0;
      pending_q <= 1'b0;
    end else begin
      irq_q <= periph_irq_i;
      if (periph_irq_i & ~irq_q) begin
        pending_q <= 1'b1;
      end else if (irq_ack_i) begin
        pending_q <= 1'b0;
      end
    end
  end

  assign irq_pending_o = pending_q;

endmodule

//--- hdl/response_merger.sv
// ----------------------------------------------------------
// Response merger
// Folds slot and unmapped responses into one manager response
// ----------------------------------------------------------

`timescale 1ns/1ps

`include "periph_bridge_defines.svh"

module response_merger
  import bus_pkg::*;
(
  input  mgr_rsp_t [`PB_NUM_SLOTS-1:0]  slot_rsp_i,
  input  logic                          unmapped_i,
  output mgr_rsp_t                      mgr_rsp_o
);

  logic                   rsp;
  logic [`PB_DATA_W-1:0]  rdata;

  // ----------------------------------------------------------
  // Merge
  // ----------------------------------------------------------

  // At most one source pulses at a time since only one
  // transaction is outstanding
  always_comb begin
    rsp   = unmapped_i;
    rdata = '0;
    for (int n = 0; n < `PB_NUM_SLOTS; n++) begin
      if (slot_rsp_i[n].rsp) begin
        rsp   = 1'b1;
        rdata = rdata | slot_rsp_i[n].rdata;
      end
    end
  end

  // Unmapped accesses fall through with zero data
  assign mgr_rsp_o.rsp   = rsp;
  assign mgr_rsp_o.rdata = rdata;

endmodule

//--- hdl/periph_bridge_top.sv
// ----------------------------------------------------------
// Peripheral bridge top
// Decoder, one APB bridge per accelerator slot and the
// response merger toward the manager
// ----------------------------------------------------------

`timescale 1ns/1ps

`include "periph_bridge_defines.svh"

module periph_bridge_top
  import bus_pkg::*, apb_pkg::*;
(
  input  logic                          clock_i,
  input  logic                          reset_i,

  // Manager port
  input  mgr_req_t                      mgr_req_i,
  output mgr_rsp_t                      mgr_rsp_o,

  // APB peripherals
  output apb_req_t [`PB_NUM_SLOTS-1:0]  apb_req_o,
  input  apb_rsp_t [`PB_NUM_SLOTS-1:0]  apb_rsp_i,

  // Interrupts
  input  logic [`PB_NUM_SLOTS-1:0]      periph_irq_i,
  input  logic [`PB_NUM_SLOTS-1:0]      irq_ack_i,
  output logic [`PB_NUM_SLOTS-1:0]      irq_pending_o
);

  mgr_req_t [`PB_NUM_SLOTS-1:0] slot_req;
  mgr_rsp_t [`PB_NUM_SLOTS-1:0] slot_rsp;
  logic                         unmapped;

  // ----------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------

  region_decoder i_region_decoder (
    .clock_i    (clock_i),
    .reset_i    (reset_i),
    .mgr_req_i  (mgr_req_i),
    .slot_req_o (slot_req),
    .unmapped_o (unmapped)
  );

  // ----------------------------------------------------------
  // Accelerator slots
  // ----------------------------------------------------------

  for (genvar n = 0; n < `PB_NUM_SLOTS; n++) begin : g_slot
    apb_slot_bridge i_apb_slot_bridge (
      .clock_i       (clock_i),
      .reset_i       (reset_i),
      .slot_req_i    (slot_req[n]),
      .slot_rsp_o    (slot_rsp[n]),
      .apb_req_o     (apb_req_o[n]),
      .apb_rsp_i     (apb_rsp_i[n]),
      .periph_irq_i  (periph_irq_i[n]),
      .irq_ack_i     (irq_ack_i[n]),
      .irq_pending_o (irq_pending_o[n])
    );
  end

  // Single response path back to the manager
  response_merger i_response_merger (
    .slot_rsp_i (slot_rsp),
    .unmapped_i (unmapped),
    .mgr_rsp_o  (mgr_rsp_o)
  );

endmodule

//--- verif/tb_clock_gen.sv
// ----------------------------------------------------------
// Testbench clock and reset
// 40 ns clock, reset held for the first two rising edges
// ----------------------------------------------------------

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clock_o,
  output logic reset_o
);

  initial begin
    clock_o = 1'b0;
    forever #20 clock_o = ~clock_o;
  end

  // Released just after the second edge
  initial begin
    reset_o = 1'b1;
    repeat (2) @(posedge clock_o);
    #1;
    reset_o = 1'b0;
  end

endmodule

//--- verif/periph_bridge_checker.sv
// ----------------------------------------------------------
// Peripheral bridge checker
// Concurrent assertions on APB protocol, response timing
// and the interrupt pending flags
// ----------------------------------------------------------

`timescale 1ns/1ps

`include "periph_bridge_defines.svh"

module periph_bridge_checker
  import bus_pkg::*, apb_pkg::*;
(
  input  logic                          clock_i,
  input  logic                          reset_i,
  input  mgr_req_t                      mgr_req_i,
  input  mgr_rsp_t                      mgr_rsp_i,
  input  apb_req_t [`PB_NUM_SLOTS-1:0]  apb_req_i,
  input  apb_rsp_t [`PB_NUM_SLOTS-1:0]  apb_rsp_i,
  input  logic [`PB_NUM_SLOTS-1:0]      periph_irq_i,
  input  logic [`PB_NUM_SLOTS-1:0]      irq_ack_i,
  input  logic [`PB_NUM_SLOTS-1:0]      irq_pending_i
);

  int                       fail_count = 0;
  logic                     strobe;
  logic [`PB_NUM_SLOTS-1:0] slot_hit;
  logic [`PB_NUM_SLOTS-1:0] psel_v;
  logic [`PB_NUM_SLOTS-1:0] done_v;

  assign strobe = mgr_req_i.rd_req | mgr_req_i.wr_req;

  // Window of each slot, straight from the address map
  always_comb begin
    for (int n = 0; n < `PB_NUM_SLOTS; n++) begin
      slot_hit[n] = (mgr_req_i.addr >= `PB_BASE_ADDR + (32'(n) << `PB_SLOT_SPAN_BITS)) &&
                    (mgr_req_i.addr < `PB_BASE_ADDR + (32'(n + 1) << `PB_SLOT_SPAN_BITS));
      psel_v[n]   = apb_req_i[n].psel;
      done_v[n]   = apb_req_i[n].psel & apb_req_i[n].penable & apb_rsp_i[n].pready;
    end
  end

  // ----------------------------------------------------------
  // Per slot APB protocol and interrupts
  // ----------------------------------------------------------

  for (genvar n = 0; n < `PB_NUM_SLOTS; n++) begin : g_slot
    // Setup always leads into access
    assert property (@(posedge clock_i) disable iff (reset_i)
      apb_req_i[n].psel && !apb_req_i[n].penable |=> apb_req_i[n].penable)
    else begin $error("slot %0d: setup not followed by access", n); fail_count++; end

    assert property (@(posedge clock_i) disable iff (reset_i)
      $rose(apb_req_i[n].penable) |-> $past(apb_req_i[n].psel))
    else begin $error("slot %0d: penable rose without a setup cycle", n); fail_count++; end

    assert property (@(posedge clock_i) disable iff (reset_i)
      apb_req_i[n].penable |-> apb_req_i[n].psel)
    else begin $error("slot %0d: penable high without psel", n); fail_count++; end

    assert property (@(posedge clock_i) disable iff (reset_i)
      apb_req_i[n].psel && $past(apb_req_i[n].psel) |->
        $stable(apb_req_i[n].paddr) && $stable(apb_req_i[n].pwrite) &&
        $stable(apb_req_i[n].pwdata))
    else begin $error("slot %0d: APB request changed while selected", n); fail_count++; end

    assert property (@(posedge clock_i) disable iff (reset_i)
      apb_req_i[n].psel |-> slot_hit[n])
    else begin $error("slot %0d: psel outside its window", n); fail_count++; end

    assert property (@(posedge clock_i) disable iff (reset_i)
      $rose(periph_irq_i[n]) |=> irq_pending_i[n])
    else begin $error("slot %0d: interrupt edge not latched", n); fail_count++; end

    // Edge beats acknowledge
    assert property (@(posedge clock_i) disable iff (reset_i)
      irq_ack_i[n] && !$rose(periph_irq_i[n]) |=> !irq_pending_i[n])
    else begin $error("slot %0d: acknowledge did not clear pending", n); fail_count++; end
  end

  // ----------------------------------------------------------
  // Manager response
  // ----------------------------------------------------------

  // Unmapped accesses answer one cycle after their strobe
  assert property (@(posedge clock_i) disable iff (reset_i)
    mgr_rsp_i.rsp |-> (|done_v) || $past(strobe && !(|slot_hit)))
  else begin $error("response without a completing transfer"); fail_count++; end

  assert property (@(posedge clock_i) disable iff (reset_i)
    (|done_v) |-> mgr_rsp_i.rsp)
  else begin $error("completed transfer without a response"); fail_count++; end

  assert property (@(posedge clock_i) disable iff (reset_i)
    strobe && !(|slot_hit) |=> mgr_rsp_i.rsp && mgr_rsp_i.rdata == '0 && psel_v == '0)
  else begin $error("unmapped access not answered as expected"); fail_count++; end

endmodule

//--- verif/periph_bridge_tb.sv
// ----------------------------------------------------------
// Peripheral bridge testbench
// Manager stimulus, three APB slave models and test reports
// ----------------------------------------------------------

`timescale 1ns/1ps

`include "periph_bridge_defines.svh"

module periph_bridge_tb
  import bus_pkg::*, apb_pkg::*;
();

  localparam int rsp_timeout   = 20;
  localparam int reset_timeout = 10;
  localparam int num_regs      = 16;

  logic                          clock;
  logic                          reset;
  mgr_req_t                      mgr_req;
  mgr_rsp_t                      mgr_rsp;
  apb_req_t [`PB_NUM_SLOTS-1:0]  apb_req;
  apb_rsp_t [`PB_NUM_SLOTS-1:0]  apb_rsp;
  logic [`PB_NUM_SLOTS-1:0]      periph_irq;
  logic [`PB_NUM_SLOTS-1:0]      irq_ack;
  logic [`PB_NUM_SLOTS-1:0]      irq_pending;
  logic [31:0]                   expected [`PB_NUM_SLOTS][num_regs];
  int                            error_count;
  int                            timeout_count;
  int                            test_count;

  tb_clock_gen i_tb_clock_gen (.clock_o(clock), .reset_o(reset));

  periph_bridge_top i_periph_bridge_top (
    .clock_i       (clock),
    .reset_i       (reset),
    .mgr_req_i     (mgr_req),
    .mgr_rsp_o     (mgr_rsp),
    .apb_req_o     (apb_req),
    .apb_rsp_i     (apb_rsp),
    .periph_irq_i  (periph_irq),
    .irq_ack_i     (irq_ack),
    .irq_pending_o (irq_pending)
  );

  bind periph_bridge_top periph_bridge_checker i_periph_bridge_checker (
    .clock_i       (clock_i),
    .reset_i       (reset_i),
    .mgr_req_i     (mgr_req_i),
    .mgr_rsp_i     (mgr_rsp_o),
    .apb_req_i     (apb_req_o),
    .apb_rsp_i     (apb_rsp_i),
    .periph_irq_i  (periph_irq_i),
    .irq_ack_i     (irq_ack_i),
    .irq_pending_i (irq_pending_o)
  );

  // Register content after reset, unique per slot and register
  function automatic logic [31:0] fill_value(int slot, int idx);
    return 32'hC0DE_0000 + 32'(slot * 256 + idx);
  endfunction

  function automatic logic [31:0] slot_addr(int slot, int idx);
    return `PB_BASE_ADDR + (32'(slot) << `PB_SLOT_SPAN_BITS) + 32'(idx * 4);
  endfunction

  function automatic int failures();
    return error_count + timeout_count + i_periph_bridge_top.i_periph_bridge_checker.fail_count;
  endfunction

  // ----------------------------------------------------------
  // APB slave models, 0 to 3 random wait states
  // ----------------------------------------------------------

  for (genvar s = 0; s < `PB_NUM_SLOTS; s++) begin : g_slave
    logic [31:0] mem [num_regs];
    apb_rsp_t    rsp_q;
    int          wait_left;

    initial begin
      rsp_q     = '0;
      wait_left = 0;
      for (int r = 0; r < num_regs; r++) begin
        mem[r] = fill_value(s, r);
      end
    end

    always @(posedge clock) begin
      #1;
      rsp_q.pready = 1'b0;
      if (apb_req[s].psel && !apb_req[s].penable) begin
        wait_left = $urandom_range(3, 0);
      end else if (apb_req[s].psel && apb_req[s].penable) begin
        if (wait_left == 0) begin
          rsp_q.pready = 1'b1;
          if (apb_req[s].pwrite) begin
            mem[apb_req[s].paddr[5:2]] = apb_req[s].pwdata;
          end else begin
            rsp_q.prdata = mem[apb_req[s].paddr[5:2]];
          end
        end else begin
          wait_left--;
        end
      end
    end

    assign apb_rsp[s] = rsp_q;
  end

  // ----------------------------------------------------------
  // Manager side helpers
  // ----------------------------------------------------------

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got == exp) else begin
      $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      error_count++;
    end
  endtask

  // One strobe, then wait for the response pulse at the falling edge
  task automatic bus_access(input logic [31:0] addr, input logic is_write,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output int latency);
    int cycles;
    mgr_req.addr   = addr;
    mgr_req.wdata  = wdata;
    mgr_req.rd_req = !is_write;
    mgr_req.wr_req = is_write;
    next_cycle();
    mgr_req.rd_req = 1'b0;
    mgr_req.wr_req = 1'b0;
    cycles = 1;
    @(negedge clock);
    while (!mgr_rsp.rsp && cycles < rsp_timeout) begin
      @(negedge clock);
      cycles++;
    end
    if (!mgr_rsp.rsp) begin
      $display("timeout: no response to the access at address %h", addr);
      timeout_count++;
    end
    rdata   = mgr_rsp.rdata;
    latency = cycles;
    next_cycle();
  endtask

  task automatic finish_test(input string name, input int fails_before);
    int fails;
    fails = failures() - fails_before;
    test_count++;
    if (fails == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d failures", name, fails);
    end
  endtask

  task automatic check_pending(input int slot, input logic exp, input string what);
    @(negedge clock);
    check_value($sformatf("slot %0d irq_pending %s", slot, what), 32'(irq_pending[slot]),
                32'(exp));
  endtask

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------

  initial begin
    int          base;
    int          cycles;
    logic [31:0] rdata;
    logic [31:0] wdata;
    logic [31:0] bad_addr [3];

    void'($urandom(32'h4166));
    mgr_req       = '0;
    periph_irq    = '0;
    irq_ack       = '0;
    error_count   = 0;
    timeout_count = 0;
    test_count    = 0;
    bad_addr      = '{32'h8003_FFFC, 32'h8007_0000, 32'h0000_1000};
    for (int s = 0; s < `PB_NUM_SLOTS; s++) begin
      for (int r = 0; r < num_regs; r++) begin
        expected[s][r] = fill_value(s, r);
      end
    end

    cycles = 0;
    while (reset !== 1'b0 && cycles < reset_timeout) begin
      @(posedge clock);
      cycles++;
    end
    if (reset !== 1'b0) begin
      $display("timeout: reset was never released");
      timeout_count++;
    end
    next_cycle();

    base = failures();
    @(negedge clock);
    for (int s = 0; s < `PB_NUM_SLOTS; s++) begin
      check_value($sformatf("slot %0d psel", s), 32'(apb_req[s].psel), 32'd0);
      check_value($sformatf("slot %0d penable", s), 32'(apb_req[s].penable), 32'd0);
    end
    check_value("response strobe", 32'(mgr_rsp.rsp), 32'd0);
    check_value("irq_pending", 32'(irq_pending), 32'd0);
    next_cycle();
    finish_test("reset", base);

    // Reads of the fill pattern, then writes and read-back
    base = failures();
    for (int s = 0; s < `PB_NUM_SLOTS; s++) begin
      bus_access(slot_addr(s, 15), 1'b0, '0, rdata, cycles);
      check_value($sformatf("slot %0d reg 15", s), rdata, expected[s][15]);
      for (int r = 0; r < 4; r++) begin
        wdata          = $urandom();
        expected[s][r] = wdata;
        bus_access(slot_addr(s, r), 1'b1, wdata, rdata, cycles);
      end
      for (int r = 0; r < 4; r++) begin
        bus_access(slot_addr(s, r), 1'b0, '0, rdata, cycles);
        check_value($sformatf("slot %0d reg %0d", s, r), rdata, expected[s][r]);
      end
    end
    finish_test("write_read", base);

    base = failures();
    for (int i = 0; i < 3; i++) begin
      bus_access(bad_addr[i], (i == 1), 32'hDEAD_BEEF, rdata, cycles);
      check_value("unmapped read data", rdata, 32'd0);
      check_value("unmapped latency", 32'(cycles), 32'd1);
    end
    finish_test("unmapped", base);

    base = failures();
    for (int s = 0; s < `PB_NUM_SLOTS; s++) begin
      periph_irq[s] = 1'b1;
      check_pending(s, 1'b0, "in the edge cycle");
      next_cycle();
      check_pending(s, 1'b1, "after the edge");
      next_cycle();
      irq_ack[s] = 1'b1;
      next_cycle();
      irq_ack[s] = 1'b0;
      check_pending(s, 1'b0, "after acknowledge");
      next_cycle();
      next_cycle();
      check_pending(s, 1'b0, "with the level held");
      next_cycle();
      periph_irq[s] = 1'b0;
      next_cycle();
      periph_irq[s] = 1'b1;
      next_cycle();
      periph_irq[s] = 1'b0;
      next_cycle();
      // New edge together with an acknowledge
      periph_irq[s] = 1'b1;
      irq_ack[s]    = 1'b1;
      next_cycle();
      irq_ack[s] = 1'b0;
      check_pending(s, 1'b1, "after edge with acknowledge");
      next_cycle();
      irq_ack[s] = 1'b1;
      next_cycle();
      irq_ack[s]    = 1'b0;
      periph_irq[s] = 1'b0;
      check_pending(s, 1'b0, "after final acknowledge");
      next_cycle();
    end
    finish_test("interrupts", base);

    $display("tests: %0d, value errors: %0d, assertion failures: %0d, timeouts: %0d",
             test_count, error_count,
             i_periph_bridge_top.i_periph_bridge_checker.fail_count, timeout_count);
    if (failures() == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- periph_bridge.f
+incdir+hdl
hdl/bus_pkg.sv
hdl/apb_pkg.sv
hdl/region_decoder.sv
hdl/apb_slot_bridge.sv
hdl/response_merger.sv
hdl/periph_bridge_top.sv
verif/tb_clock_gen.sv
verif/periph_bridge_checker.sv
verif/periph_bridge_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the periph_bridge testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

build_dir=build
log_file=sim.log

verilator --binary --timing --assert \
  --top-module periph_bridge_tb \
  --Mdir "$build_dir" \
  -o periph_bridge_sim \
  -f periph_bridge.f

"$build_dir/periph_bridge_sim" +verilator+error+limit+1000 2>&1 | tee "$log_file"

if grep -q "SIMULATION FAILED" "$log_file"; then
  echo "Simulation reported a failure, see $log_file"
  exit 1
fi
echo "Simulation finished without failures"
